/* logic/slink_attr_cfg.svh */
`ifndef SLINK_ATTR_CFG_SVH
`define SLINK_ATTR_CFG_SVH

// Attribute address and data width.
`define SLINK_ATTR_W            16

// TX lane bus.
`define SLINK_NUM_LANES         4
`define SLINK_LANE_W            8

// Remote writes waiting for the link.
`define SLINK_SEND_FIFO_DEPTH   2

// First lane of an attribute-write header beat.
`define SLINK_OP_ATTR_WR_BYTE   8'hA5

// Attribute reset values
`define SLINK_RST_ACTIVE_TXS    3
`define SLINK_RST_ACTIVE_RXS    3
`define SLINK_RST_HARD_RESET_US 100
`define SLINK_RST_PX_CLK_TRAIL  32
`define SLINK_RST_P1_TS1_TX     16
`define SLINK_RST_P1_TS2_TX     8
`define SLINK_RST_SYNC_FREQ     15

`endif

/* logic/slink_attr_cmd_port.sv */
`timescale 1ns/100ps
`default_nettype none

module slink_attr_cmd_port import slink_attr_pkg::*; (
  input  logic       link_clk,
  input  logic       reset,
  input  logic       cmd_valid,
  input  attr_cmd_t  cmd,
  output logic       cmd_ready,
  output logic       tbl_wr_en,
  output attr_wr_t   tbl_wr,
  output logic       apply,
  output logic       push,
  output attr_wr_t   push_data,
  input  logic       full
);

logic       cmd_q_valid;
attr_cmd_t  cmd_q;
logic       remote_blocked;
logic       accept;

// Only a remote write stuck behind a full FIFO holds the port.
assign remote_blocked = cmd_q_valid && (cmd_q.op == CMD_WRITE_REMOTE) && full;
assign cmd_ready      = !remote_blocked;
assign accept         = cmd_valid && cmd_ready;

always_ff @(posedge link_clk) begin
  if (reset) begin
    cmd_q_valid <= 1'b0;
  end else if (accept) begin
    cmd_q_valid <= 1'b1;
  end else if (!remote_blocked) begin
    cmd_q_valid <= 1'b0;                  // Issued this cycle.
  end
end

always_ff @(posedge link_clk) begin
  if (accept) begin
    cmd_q <= cmd;
  end
end

assign tbl_wr_en = cmd_q_valid && (cmd_q.op == CMD_WRITE_LOCAL);
assign apply     = cmd_q_valid && (cmd_q.op == CMD_APPLY);
assign push      = cmd_q_valid && (cmd_q.op == CMD_WRITE_REMOTE) && !full;

assign tbl_wr    = '{addr: cmd_q.addr, wdata: cmd_q.wdata};
assign push_data = '{addr: cmd_q.addr, wdata: cmd_q.wdata};

a_no_push_full: assert property (@(posedge link_clk) disable iff (reset)
  push |-> !full);

endmodule

`default_nettype wire

/* logic/slink_attr_front_end.sv */
`timescale 1ns/100ps
`default_nettype none

module slink_attr_front_end import slink_attr_pkg::*; (
  input  logic         link_clk,
  input  logic         reset,
  input  logic         cmd_valid,
  input  attr_cmd_t    cmd,
  output logic         cmd_ready,
  input  logic [15:0]  rd_addr,
  output logic [15:0]  rd_data,
  output attr_eff_t    eff,
  output logic         tx_valid,
  input  logic         tx_ready,
  output lane_beat_t   tx_data
);

logic      tbl_wr_en;
attr_wr_t  tbl_wr;
logic      apply;
logic      push;
attr_wr_t  push_data;
logic      full;
logic      pop;
attr_wr_t  pop_data;
logic      empty;

slink_attr_cmd_port u_cmd_port (
  .link_clk   ( link_clk   ),
  .reset      ( reset      ),
  .cmd_valid  ( cmd_valid  ),
  .cmd        ( cmd        ),
  .cmd_ready  ( cmd_ready  ),
  .tbl_wr_en  ( tbl_wr_en  ),
  .tbl_wr     ( tbl_wr     ),
  .apply      ( apply      ),
  .push       ( push       ),
  .push_data  ( push_data  ),
  .full       ( full       ));

slink_attr_send_fifo u_send_fifo (
  .link_clk   ( link_clk   ),
  .reset      ( reset      ),
  .push       ( push       ),
  .push_data  ( push_data  ),
  .full       ( full       ),
  .pop        ( pop        ),
  .pop_data   ( pop_data   ),
  .empty      ( empty      ));

slink_attr_pkt_tx u_pkt_tx (
  .link_clk   ( link_clk   ),
  .reset      ( reset      ),
  .empty      ( empty      ),
  .pop_data   ( pop_data   ),
  .pop        ( pop        ),
  .tx_valid   ( tx_valid   ),
  .tx_ready   ( tx_ready   ),
  .tx_data    ( tx_data    ));

slink_attr_table u_table (
  .link_clk   ( link_clk   ),
  .reset      ( reset      ),
  .tbl_wr_en  ( tbl_wr_en  ),
  .tbl_wr     ( tbl_wr     ),
  .apply      ( apply      ),
  .rd_addr    ( rd_addr    ),
  .rd_data    ( rd_data    ),
  .eff        ( eff        ));

endmodule

`default_nettype wire

/* logic/slink_attr_pkg.sv */
`default_nettype none

`include "slink_attr_cfg.svh"

package slink_attr_pkg;

  typedef enum logic [1:0] {
    CMD_NOP          = 2'd0,
    CMD_WRITE_LOCAL  = 2'd1,
    CMD_WRITE_REMOTE = 2'd2,
    CMD_APPLY        = 2'd3
  } attr_cmd_op_e;

  typedef enum logic [`SLINK_ATTR_W-1:0] {
    ADDR_ACTIVE_TXS    = 16'd0,
    ADDR_ACTIVE_RXS    = 16'd1,
    ADDR_HARD_RESET_US = 16'd2,
    ADDR_PX_CLK_TRAIL  = 16'd3,
    ADDR_P1_TS1_TX     = 16'd4,
    ADDR_P1_TS2_TX     = 16'd5,
    ADDR_SYNC_FREQ     = 16'd6
  } attr_addr_e;

  typedef enum logic [1:0] {
    TX_IDLE = 2'd0,
    TX_HDR  = 2'd1,
    TX_DATA = 2'd2
  } pkt_tx_state_e;

  typedef struct packed {
    attr_cmd_op_e              op;
    logic [`SLINK_ATTR_W-1:0]  addr;
    logic [`SLINK_ATTR_W-1:0]  wdata;
  } attr_cmd_t;

  // Queue entry and table write port.
  typedef struct packed {
    logic [`SLINK_ATTR_W-1:0]  addr;
    logic [`SLINK_ATTR_W-1:0]  wdata;
  } attr_wr_t;

  typedef struct packed {
    logic [2:0]   active_txs;
    logic [2:0]   active_rxs;
    logic [9:0]   hard_reset_us;
    logic [7:0]   px_clk_trail;
    logic [15:0]  p1_ts1_tx;
    logic [15:0]  p1_ts2_tx;
    logic [7:0]   sync_freq;
  } attr_eff_t;

  typedef struct packed {
    logic [`SLINK_NUM_LANES-1:0][`SLINK_LANE_W-1:0] lane; // lane[0] is the low byte.
  } lane_beat_t;

endpackage

`default_nettype wire

/* logic/slink_attr_pkt_tx.sv */
`timescale 1ns/100ps
`default_nettype none

`include "slink_attr_cfg.svh"

module slink_attr_pkt_tx import slink_attr_pkg::*; (
  input  logic        link_clk,
  input  logic        reset,
  input  logic        empty,
  input  attr_wr_t    pop_data,
  output logic        pop,
  output logic        tx_valid,
  input  logic        tx_ready,
  output lane_beat_t  tx_data
);

pkt_tx_state_e  state_q;
pkt_tx_state_e  state_d;
attr_wr_t       ent_q;
logic           load;

always_comb begin
  state_d = state_q;
  load    = 1'b0;
  case (state_q)
    TX_IDLE: begin
      if (!empty) begin
        state_d = TX_HDR;
        load    = 1'b1;
      end
    end
    TX_HDR: begin
      if (tx_ready) begin
        state_d = TX_DATA;
      end
    end
    TX_DATA: begin
      if (tx_ready) begin
        if (!empty) begin
          state_d = TX_HDR;               // Back to back packets.
          load    = 1'b1;
        end else begin
          state_d = TX_IDLE;
        end
      end
    end
    default: begin
      state_d = TX_IDLE;
    end
  endcase
end

always_ff @(posedge link_clk) begin
  if (reset) begin
    state_q <= TX_IDLE;
  end else begin
    state_q <= state_d;
  end
end

always_ff @(posedge link_clk) begin
  if (load) begin
    ent_q <= pop_data;
  end
end

// The entry leaves the FIFO once its header is on the link.
assign pop      = (state_q == TX_HDR) && tx_ready;
assign tx_valid = (state_q != TX_IDLE);

always_comb begin
  tx_data = '0;
  case (state_q)
    TX_HDR: begin
      tx_data.lane[0] = `SLINK_OP_ATTR_WR_BYTE;
      tx_data.lane[1] = ent_q.addr[15:8];
      tx_data.lane[2] = ent_q.addr[7:0];
    end
    TX_DATA: begin
      tx_data.lane[0] = ent_q.wdata[15:8];
      tx_data.lane[1] = ent_q.wdata[7:0];
    end
    default: begin
      tx_data = '0;
    end
  endcase
end

a_beat_held: assert property (@(posedge link_clk) disable iff (reset)
  tx_valid && !tx_ready |=> tx_valid && $stable(tx_data));

endmodule

`default_nettype wire

/* logic/slink_attr_send_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

`include "slink_attr_cfg.svh"

module slink_attr_send_fifo import slink_attr_pkg::*; (
  input  logic      link_clk,
  input  logic      reset,
  input  logic      push,
  input  attr_wr_t  push_data,
  output logic      full,
  input  logic      pop,
  output attr_wr_t  pop_data,
  output logic      empty
);

localparam int DEPTH = `SLINK_SEND_FIFO_DEPTH;
localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_W = $clog2(DEPTH + 1);

attr_wr_t          mem [DEPTH];
logic [PTR_W-1:0]  wr_ptr;
logic [PTR_W-1:0]  rd_ptr;
logic [CNT_W-1:0]  count;

function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
  if (ptr == PTR_W'(DEPTH - 1)) begin
    return '0;
  end
  return ptr + 1'b1;
endfunction

always_ff @(posedge link_clk) begin
  if (reset) begin
    wr_ptr <= '0;
    rd_ptr <= '0;
    count  <= '0;
  end else begin
    if (push) begin
      wr_ptr <= ptr_next(wr_ptr);
    end
    if (pop) begin
      rd_ptr <= ptr_next(rd_ptr);
    end
    if (push && !pop) begin
      count <= count + 1'b1;
    end else if (pop && !push) begin
      count <= count - 1'b1;
    end
  end
end

always_ff @(posedge link_clk) begin
  if (push) begin
    mem[wr_ptr] <= push_data;
  end
end

assign pop_data = mem[rd_ptr];              // Head entry, shown before the pop.
assign full     = (count == CNT_W'(DEPTH));
assign empty    = (count == '0);

a_no_overflow: assert property (@(posedge link_clk) disable iff (reset)
  push |-> !full);

a_no_underflow: assert property (@(posedge link_clk) disable iff (reset)
  pop |-> !empty);

endmodule

`default_nettype wire

/* logic/slink_attr_table.sv */
`timescale 1ns/100ps
`default_nettype none

`include "slink_attr_cfg.svh"

module slink_attr_table import slink_attr_pkg::*; (
  input  logic         link_clk,
  input  logic         reset,
  input  logic         tbl_wr_en,
  input  attr_wr_t     tbl_wr,
  input  logic         apply,
  input  logic [15:0]  rd_addr,
  output logic [15:0]  rd_data,
  output attr_eff_t    eff
);

localparam attr_eff_t RST_VAL = '{
  active_txs:    3'(`SLINK_RST_ACTIVE_TXS),
  active_rxs:    3'(`SLINK_RST_ACTIVE_RXS),
  hard_reset_us: 10'(`SLINK_RST_HARD_RESET_US),
  px_clk_trail:  8'(`SLINK_RST_PX_CLK_TRAIL),
  p1_ts1_tx:     16'(`SLINK_RST_P1_TS1_TX),
  p1_ts2_tx:     16'(`SLINK_RST_P1_TS2_TX),
  sync_freq:     8'(`SLINK_RST_SYNC_FREQ)
};

attr_eff_t  shadow_q;
attr_eff_t  eff_q;

// Each field keeps only the low bits of the written data.
always_ff @(posedge link_clk) begin
  if (reset) begin
    shadow_q <= RST_VAL;
  end else if (tbl_wr_en) begin
    case (tbl_wr.addr)
      ADDR_ACTIVE_TXS:    shadow_q.active_txs    <= tbl_wr.wdata[2:0];
      ADDR_ACTIVE_RXS:    shadow_q.active_rxs    <= tbl_wr.wdata[2:0];
      ADDR_HARD_RESET_US: shadow_q.hard_reset_us <= tbl_wr.wdata[9:0];
      ADDR_PX_CLK_TRAIL:  shadow_q.px_clk_trail  <= tbl_wr.wdata[7:0];
      ADDR_P1_TS1_TX:     shadow_q.p1_ts1_tx     <= tbl_wr.wdata;
      ADDR_P1_TS2_TX:     shadow_q.p1_ts2_tx     <= tbl_wr.wdata;
      ADDR_SYNC_FREQ:     shadow_q.sync_freq     <= tbl_wr.wdata[7:0];
      default: begin
        shadow_q <= shadow_q;             // Unmapped address.
      end
    endcase
  end
end

always_ff @(posedge link_clk) begin
  if (reset) begin
    eff_q <= RST_VAL;
  end else if (apply) begin
    eff_q <= shadow_q;
  end
end

assign eff = eff_q;

always_comb begin
  case (rd_addr)
    ADDR_ACTIVE_TXS:    rd_data = 16'(shadow_q.active_txs);
    ADDR_ACTIVE_RXS:    rd_data = 16'(shadow_q.active_rxs);
    ADDR_HARD_RESET_US: rd_data = 16'(shadow_q.hard_reset_us);
    ADDR_PX_CLK_TRAIL:  rd_data = 16'(shadow_q.px_clk_trail);
    ADDR_P1_TS1_TX:     rd_data = shadow_q.p1_ts1_tx;
    ADDR_P1_TS2_TX:     rd_data = shadow_q.p1_ts2_tx;
    ADDR_SYNC_FREQ:     rd_data = 16'(shadow_q.sync_freq);
    default:            rd_data = 16'd0;
  endcase
end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the slink attribute front end testbench with Verilator.

cd "$(dirname "$0")" || exit 1

TOP=tb_slink_attr_front_end
OBJ=obj_dir
LOG=sim.log

verilator --binary --assert -f sources.f --top-module "$TOP" -Mdir "$OBJ"
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

"./$OBJ/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
  echo "FAIL"
  exit 1
fi

echo "PASS"
exit 0

/* sources.f */
+incdir+logic
logic/slink_attr_pkg.sv
logic/slink_attr_cmd_port.sv
logic/slink_attr_send_fifo.sv
logic/slink_attr_pkt_tx.sv
logic/slink_attr_table.sv
logic/slink_attr_front_end.sv
test/slink_attr_checker.sv
test/tb_slink_attr_front_end.sv

/* test/slink_attr_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "slink_attr_cfg.svh"

module slink_attr_checker import slink_attr_pkg::*; (
  input  logic         link_clk,
  input  logic         reset,
  input  logic         cmd_valid,
  input  attr_cmd_t    cmd,
  input  logic         cmd_ready,
  input  logic [15:0]  rd_addr,
  input  logic [15:0]  rd_data,
  input  attr_eff_t    eff,
  input  logic         tx_valid,
  input  logic         tx_ready,
  input  lane_beat_t   tx_data,
  input  logic         check_req,
  input  int           row_idx,
  input  logic [15:0]  exp_rd,
  input  logic         exp_busy,
  output int           err_count,
  output int           check_count,
  output int           pending
);

logic [15:0]  shadow_m [7];
logic [15:0]  eff_m [7];
logic [31:0]  beat_q [$];
logic         prev_stall;
logic [31:0]  prev_data;
logic         prev_reset;
int           last_err;

// Field widths of the attribute map: 3, 3, 10, 8, 16, 16, 8.
function automatic logic [15:0] field_mask(input int idx);
  case (idx)
    0, 1:    return 16'h0007;
    2:       return 16'h03FF;
    3, 6:    return 16'h00FF;
    default: return 16'hFFFF;
  endcase
endfunction

function automatic logic [15:0] model_read(input logic [15:0] addr);
  if (addr > 16'd6) begin
    return 16'd0;
  end
  return shadow_m[int'(addr)];
endfunction

task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
  check_count = check_count + 1;
  if (exp !== got) begin
    err_count = err_count + 1;
    $display("ERR %0t %s exp %h got %h", $time, name, exp, got);
  end
endtask

task automatic reset_model();
  shadow_m[0] = 16'(`SLINK_RST_ACTIVE_TXS);
  shadow_m[1] = 16'(`SLINK_RST_ACTIVE_RXS);
  shadow_m[2] = 16'(`SLINK_RST_HARD_RESET_US);
  shadow_m[3] = 16'(`SLINK_RST_PX_CLK_TRAIL);
  shadow_m[4] = 16'(`SLINK_RST_P1_TS1_TX);
  shadow_m[5] = 16'(`SLINK_RST_P1_TS2_TX);
  shadow_m[6] = 16'(`SLINK_RST_SYNC_FREQ);
  eff_m = shadow_m;
  beat_q.delete();
endtask

initial begin
  err_count   = 0;
  check_count = 0;
  pending     = 0;
  last_err    = 0;
  prev_stall  = 1'b0;
  prev_data   = '0;
  prev_reset  = 1'b1;
  reset_model();
end

always @(posedge link_clk) begin
  if (reset) begin
    reset_model();
    prev_stall = 1'b0;
  end else begin
    if (prev_reset) begin
      compare("tx_valid", 32'd0, 32'(tx_valid));  // Idle link right after reset.
      compare("cmd_ready", 32'd1, 32'(cmd_ready));
    end
    if (prev_stall) begin
      compare("tx_valid", 32'd1, 32'(tx_valid));
      compare("tx_data", prev_data, 32'(tx_data));
    end
    if (tx_valid && tx_ready) begin
      if (beat_q.size() == 0) begin
        err_count = err_count + 1;
        $display("Beat sent at %0t with no packet expected", $time);
      end else begin
        compare("tx_data", beat_q.pop_front(), 32'(tx_data));
      end
    end
    if (cmd_valid && cmd_ready) begin
      case (cmd.op)
        CMD_WRITE_LOCAL: begin
          if (cmd.addr <= 16'd6) begin
            shadow_m[int'(cmd.addr)] = cmd.wdata & field_mask(int'(cmd.addr));
          end
        end
        CMD_WRITE_REMOTE: begin
          beat_q.push_back({8'h00, cmd.addr[7:0], cmd.addr[15:8], `SLINK_OP_ATTR_WR_BYTE});
          beat_q.push_back({16'h0000, cmd.wdata[7:0], cmd.wdata[15:8]});
        end
        CMD_APPLY: begin
          eff_m = shadow_m;
        end
        default: begin
        end
      endcase
    end
    if (check_req) begin
      compare("rd_data", 32'(model_read(rd_addr)), 32'(rd_data));
      compare("rd_data", 32'(exp_rd), 32'(rd_data));   // Hand-worked table value.
      compare("eff.active_txs", 32'(eff_m[0]), 32'(eff.active_txs));
      compare("eff.active_rxs", 32'(eff_m[1]), 32'(eff.active_rxs));
      compare("eff.hard_reset_us", 32'(eff_m[2]), 32'(eff.hard_reset_us));
      compare("eff.px_clk_trail", 32'(eff_m[3]), 32'(eff.px_clk_trail));
      compare("eff.p1_ts1_tx", 32'(eff_m[4]), 32'(eff.p1_ts1_tx));
      compare("eff.p1_ts2_tx", 32'(eff_m[5]), 32'(eff.p1_ts2_tx));
      compare("eff.sync_freq", 32'(eff_m[6]), 32'(eff.sync_freq));
      if (exp_busy) begin
        compare("cmd_ready", 32'd0, 32'(cmd_ready));
      end
      if (err_count == last_err) begin
        $display("row %0d ok", row_idx);
      end else begin
        $display("row %0d failed", row_idx);
      end
      last_err = err_count;
    end
    prev_stall = tx_valid && !tx_ready;
    prev_data  = 32'(tx_data);
  end
  prev_reset = reset;
  pending    = beat_q.size();
end

endmodule

`default_nettype wire

/* test/tb_slink_attr_front_end.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_slink_attr_front_end import slink_attr_pkg::*; ();

typedef struct packed {
  attr_cmd_op_e  op;
  logic [15:0]   addr;
  logic [15:0]   wdata;
  logic [15:0]   rd_addr;
  logic [15:0]   exp_rd;
  logic [1:0]    duty;       // 0 low, 1 high, 2 random.
  logic          exp_busy;
} row_t;

logic        link_clk;
logic        reset;
logic        cmd_valid;
attr_cmd_t   cmd;
logic        cmd_ready;
logic [15:0] rd_addr;
logic [15:0] rd_data;
attr_eff_t   eff;
logic        tx_valid;
logic        tx_ready;
lane_beat_t  tx_data;
logic        check_req;
int          row_idx;
logic [15:0] exp_rd;
logic        exp_busy;
int          err_count;
int          check_count;
int          pending;
logic [1:0]  duty;
row_t        rows [$];

slink_attr_front_end u_slink_attr_front_end (
  .link_clk  ( link_clk  ),
  .reset     ( reset     ),
  .cmd_valid ( cmd_valid ),
  .cmd       ( cmd       ),
  .cmd_ready ( cmd_ready ),
  .rd_addr   ( rd_addr   ),
  .rd_data   ( rd_data   ),
  .eff       ( eff       ),
  .tx_valid  ( tx_valid  ),
  .tx_ready  ( tx_ready  ),
  .tx_data   ( tx_data   ));

slink_attr_checker u_checker (
  .link_clk    ( link_clk    ),
  .reset       ( reset       ),
  .cmd_valid   ( cmd_valid   ),
  .cmd         ( cmd         ),
  .cmd_ready   ( cmd_ready   ),
  .rd_addr     ( rd_addr     ),
  .rd_data     ( rd_data     ),
  .eff         ( eff         ),
  .tx_valid    ( tx_valid    ),
  .tx_ready    ( tx_ready    ),
  .tx_data     ( tx_data     ),
  .check_req   ( check_req   ),
  .row_idx     ( row_idx     ),
  .exp_rd      ( exp_rd      ),
  .exp_busy    ( exp_busy    ),
  .err_count   ( err_count   ),
  .check_count ( check_count ),
  .pending     ( pending     ));

initial link_clk = 1'b0;
always #20 link_clk = ~link_clk;

task automatic add_row(input attr_cmd_op_e op, input logic [15:0] addr, input logic [15:0] wdata,
                       input logic [15:0] ra, input logic [15:0] rd, input logic [1:0] dt,
                       input logic busy);
  rows.push_back('{op: op, addr: addr, wdata: wdata, rd_addr: ra, exp_rd: rd,
                   duty: dt, exp_busy: busy});
endtask

task automatic wait_accept();
  do begin
    @(posedge link_clk);
  end while (!cmd_ready);
endtask

initial begin
  logic [31:0] rnd;
  void'($urandom(32'h2b2));
  forever begin
    @(negedge link_clk);
    rnd = $urandom;
    case (duty)
      2'd0:    tx_ready <= 1'b0;
      2'd1:    tx_ready <= 1'b1;
      default: tx_ready <= rnd[0];
    endcase
  end
end

initial begin
  for (int a = 0; a < 7; a++) begin
    add_row(CMD_NOP, 16'd0, 16'd0, 16'(a), 16'd0, 2'd1, 1'b0);
  end
  rows[0].exp_rd = 16'd3;                  // Reset values of addresses 0 to 6.
  rows[1].exp_rd = 16'd3;
  rows[2].exp_rd = 16'd100;
  rows[3].exp_rd = 16'd32;
  rows[4].exp_rd = 16'd16;
  rows[5].exp_rd = 16'd8;
  rows[6].exp_rd = 16'd15;
  add_row(CMD_WRITE_LOCAL, 16'd2, 16'hFFFF, 16'd2, 16'h03FF, 2'd1, 1'b0);
  add_row(CMD_WRITE_LOCAL, 16'd0, 16'h000D, 16'd0, 16'h0005, 2'd1, 1'b0);
  add_row(CMD_WRITE_LOCAL, 16'd7, 16'h1234, 16'd7, 16'h0000, 2'd1, 1'b0);
  add_row(CMD_WRITE_LOCAL, 16'd6, 16'h0177, 16'd6, 16'h0077, 2'd1, 1'b0);
  add_row(CMD_WRITE_LOCAL, 16'd4, 16'hBEEF, 16'd4, 16'hBEEF, 2'd1, 1'b0);
  add_row(CMD_APPLY, 16'd0, 16'd0, 16'd2, 16'h03FF, 2'd1, 1'b0);
  add_row(CMD_WRITE_REMOTE, 16'h0102, 16'hCAFE, 16'd2, 16'h03FF, 2'd1, 1'b0);
  add_row(CMD_WRITE_REMOTE, 16'd5, 16'h5555, 16'd5, 16'd8, 2'd1, 1'b0);
  add_row(CMD_WRITE_REMOTE, 16'h0010, 16'h1111, 16'd0, 16'd5, 2'd0, 1'b0);
  add_row(CMD_WRITE_REMOTE, 16'h0020, 16'h2222, 16'd0, 16'd5, 2'd0, 1'b0);
  add_row(CMD_WRITE_REMOTE, 16'h0030, 16'h3333, 16'd0, 16'd5, 2'd0, 1'b1);
  add_row(CMD_NOP, 16'd0, 16'd0, 16'd0, 16'd5, 2'd1, 1'b0);
  add_row(CMD_WRITE_REMOTE, 16'd3, 16'hAAAA, 16'd3, 16'd32, 2'd2, 1'b0);
  add_row(CMD_WRITE_LOCAL, 16'd3, 16'h0044, 16'd3, 16'h0044, 2'd2, 1'b0);
  add_row(CMD_WRITE_REMOTE, 16'd1, 16'h0007, 16'd1, 16'd3, 2'd2, 1'b0);
  add_row(CMD_APPLY, 16'd0, 16'd0, 16'd3, 16'h0044, 2'd2, 1'b0);
  add_row(CMD_WRITE_LOCAL, 16'd1, 16'h000F, 16'd1, 16'd7, 2'd2, 1'b0);
  add_row(CMD_WRITE_REMOTE, 16'h00FF, 16'h0BAD, 16'd0, 16'd5, 2'd2, 1'b0);
  add_row(CMD_APPLY, 16'd0, 16'd0, 16'd1, 16'd7, 2'd2, 1'b0);

  reset     = 1'b1;
  cmd_valid = 1'b0;
  cmd       = '0;
  rd_addr   = '0;
  duty      = 2'd1;
  tx_ready  = 1'b0;
  check_req = 1'b0;
  row_idx   = 0;
  exp_rd    = '0;
  exp_busy  = 1'b0;
  repeat (16) @(posedge link_clk);
  @(negedge link_clk);
  reset = 1'b0;

  foreach (rows[i]) begin
    @(posedge link_clk);
    duty = rows[i].duty;
    @(negedge link_clk);
    rd_addr   = rows[i].rd_addr;
    cmd       = '{op: rows[i].op, addr: rows[i].addr, wdata: rows[i].wdata};
    cmd_valid = 1'b1;
    wait_accept();
    @(negedge link_clk);
    cmd_valid = 1'b0;
    repeat (4) @(negedge link_clk);
    row_idx   = i;
    exp_rd    = rows[i].exp_rd;
    exp_busy  = rows[i].exp_busy;
    check_req = 1'b1;
    @(negedge link_clk);
    check_req = 1'b0;
  end

  @(posedge link_clk);
  duty = 2'd1;
  while (pending != 0 || tx_valid) begin  // Let queued packets drain.
    @(negedge link_clk);
  end
  repeat (2) @(negedge link_clk);
  $display("rows %0d, checks %0d, errors %0d", rows.size(), check_count, err_count);
  if (err_count == 0) begin
    $display("Done: no errors");
  end else begin
    $display("Done: errors found");
  end
  $finish;
end

initial begin
  int limit;
  #1;
  limit = rows.size() * 40 + 200;
  repeat (limit) @(posedge link_clk);
  $display("Timeout after %0d cycles, the run did not finish", limit);
  $display("Done: errors found");
  $finish;
end

endmodule

`default_nettype wire
